/* common/riscv_isa_pkg.sv */
package riscv_isa_pkg;

   typedef logic [31:0] insn_t;
   typedef logic [6:0]  opcode_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;
   typedef logic [11:0] funct12_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [11:0] csr_addr_t;

   localparam opcode_t OPC_LOAD   = 7'h03;
   localparam opcode_t OPC_FENCE  = 7'h0f;
   localparam opcode_t OPC_OP_IMM = 7'h13;
   localparam opcode_t OPC_AUIPC  = 7'h17;
   localparam opcode_t OPC_STORE  = 7'h23;
   localparam opcode_t OPC_OP     = 7'h33;
   localparam opcode_t OPC_LUI    = 7'h37;
   localparam opcode_t OPC_BRANCH = 7'h63;
   localparam opcode_t OPC_JALR   = 7'h67;
   localparam opcode_t OPC_JAL    = 7'h6f;
   localparam opcode_t OPC_SYSTEM = 7'h73;

   localparam funct7_t F7_BASE   = 7'h00;
   localparam funct7_t F7_ALT    = 7'h20; // sub, sra
   localparam funct7_t F7_MULDIV = 7'h01;

   // privileged encodings with funct3 zero
   localparam funct12_t F12_ECALL  = 12'h000;
   localparam funct12_t F12_EBREAK = 12'h001;
   localparam funct12_t F12_WFI    = 12'h105;
   localparam funct12_t F12_MRET   = 12'h302;

   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MISA     = 12'h301;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;
   localparam csr_addr_t CSR_MIP      = 12'h344;
   localparam csr_addr_t CSR_CYCLE    = 12'hc00;
   localparam csr_addr_t CSR_INSTRET  = 12'hc02;
   localparam csr_addr_t CSR_MHARTID  = 12'hf14;

   typedef enum logic [3:0]
   {
      MSTATUS, MISA, MIE, MTVEC, MSCRATCH, MEPC, MCAUSE, MTVAL, MIP,
      CYCLE_CSR, INSTRET_CSR, MHARTID, BAD_CSR
   } csr_t;

   localparam reg_idx_t LINK_REG_A = 5'd1; // ra
   localparam reg_idx_t LINK_REG_B = 5'd5; // t0, alternate link

endpackage

/* common/uop_pkg.sv */
package uop_pkg;

   import riscv_isa_pkg::*;

   localparam int XLEN = 64;

   typedef logic [XLEN-1:0] xlen_t;

   typedef enum logic [6:0]
   {
      NOP, ILLEGAL, FETCH_PF, IRQ,
      // register-register
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      // register-immediate
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
      LUI, AUIPC,
      // m extension
      MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
      LB, LH, LW, LD, LBU, LHU, LWU,
      SB, SH, SW, SD,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      JAL, J, JALR, JR, RET,
      ECALL, EBREAK, MRET,
      CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
      RDCYCLE, RDINSTRET
   } uop_op_t;

   typedef struct packed
   {
      uop_op_t  op;
      reg_idx_t dst;
      reg_idx_t src_a;
      reg_idx_t src_b;
      logic     dst_valid;
      logic     src_a_valid;
      logic     src_b_valid;
      xlen_t    imm;
      logic     is_int;
      logic     is_cheap_int; // single cycle alu op
      logic     is_mem;
      logic     is_store;
      logic     is_br;
      logic     serializing;
      logic     must_restart; // refetch after retire
   } uop_t;

   localparam uop_t UOP_NONE = '{op: ILLEGAL, default: '0};

endpackage

/* source/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen
   import riscv_isa_pkg::*;
   import uop_pkg::*;
(
   input  insn_t insn,
   input  xlen_t pc,
   output xlen_t imm_i,
   output xlen_t imm_s,
   output xlen_t imm_u,
   output xlen_t pc_target
);

   opcode_t opcode;
   xlen_t   imm_b;
   xlen_t   imm_j;
   xlen_t   pc_offset;

   assign opcode = insn[6:0];

   assign imm_i = {{52{insn[31]}}, insn[31:20]};
   assign imm_s = {{52{insn[31]}}, insn[31:25], insn[11:7]};
   assign imm_u = {{32{insn[31]}}, insn[31:12], 12'd0};
   assign imm_b = {{51{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm_j = {{43{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

   always_comb
   begin
      case (opcode)
         OPC_BRANCH:
            pc_offset = imm_b;
         OPC_JAL:
            pc_offset = imm_j;
         OPC_AUIPC:
            pc_offset = imm_u;
         default:
            pc_offset = '0;
      endcase
   end

   assign pc_target = pc + pc_offset; // shared by auipc, branches, jal

endmodule

/* decode/alu_decode.sv */
`timescale 1ns/10ps

module alu_decode
   import riscv_isa_pkg::*;
   import uop_pkg::*;
#(
   parameter bit CHEAP_TWO_SRC = 1'b0
)
(
   input  insn_t insn,
   input  xlen_t imm_i,
   input  xlen_t imm_u,
   input  xlen_t pc_target,
   output uop_t  uop,
   output logic  match
);

   opcode_t  opcode;
   funct3_t  funct3;
   funct7_t  funct7;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;

   assign opcode = insn[6:0];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];
   assign rd     = insn[11:7];
   assign rs1    = insn[19:15];
   assign rs2    = insn[24:20];

   always_comb
   begin
      uop = UOP_NONE;
      match = 1'b1;
      uop.dst = rd;
      uop.dst_valid = 1'b1;
      uop.is_int = 1'b1;
      case (opcode)
         OPC_OP_IMM:
         begin
            uop.src_a = rs1;
            uop.src_a_valid = 1'b1;
            uop.imm = imm_i;
            uop.is_cheap_int = 1'b1;
            case (funct3)
               3'd0: uop.op = ADDI;
               3'd1: uop.op = (funct7[6:1] == F7_BASE[6:1]) ? SLLI : ILLEGAL;
               3'd2: uop.op = SLTI;
               3'd3: uop.op = SLTIU;
               3'd4: uop.op = XORI;
               3'd5:
               begin
                  if (funct7[6:1] == F7_BASE[6:1]) // shamt takes bit 25 on rv64
                     uop.op = SRLI;
                  else if (funct7[6:1] == F7_ALT[6:1])
                     uop.op = SRAI;
               end
               3'd6: uop.op = ORI;
               default: uop.op = ANDI;
            endcase
         end
         OPC_OP:
         begin
            uop.src_a = rs1;
            uop.src_b = rs2;
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_cheap_int = CHEAP_TWO_SRC && (funct7 != F7_MULDIV);
            case (funct7)
               F7_BASE:
               begin
                  case (funct3)
                     3'd0: uop.op = ADD;
                     3'd1: uop.op = SLL;
                     3'd2: uop.op = SLT;
                     3'd3: uop.op = SLTU;
                     3'd4: uop.op = XOR;
                     3'd5: uop.op = SRL;
                     3'd6: uop.op = OR;
                     default: uop.op = AND;
                  endcase
               end
               F7_ALT:
               begin
                  if (funct3 == 3'd0)
                     uop.op = SUB;
                  else if (funct3 == 3'd5)
                     uop.op = SRA;
               end
               F7_MULDIV:
               begin
                  case (funct3)
                     3'd0: uop.op = MUL;
                     3'd1: uop.op = MULH;
                     3'd2: uop.op = MULHSU;
                     3'd3: uop.op = MULHU;
                     3'd4: uop.op = DIV;
                     3'd5: uop.op = DIVU;
                     3'd6: uop.op = REM;
                     default: uop.op = REMU;
                  endcase
               end
               default: ;
            endcase
         end
         OPC_LUI:
         begin
            uop.op = LUI;
            uop.imm = imm_u;
            uop.is_cheap_int = 1'b1;
         end
         OPC_AUIPC:
         begin
            uop.op = AUIPC;
            uop.imm = pc_target; // target folded in at decode
            uop.is_cheap_int = 1'b1;
         end
         default:
            match = 1'b0;
      endcase

      if (uop.op == ILLEGAL)
         uop = UOP_NONE;
      else if (rd == '0)
      begin
         uop = UOP_NONE;
         uop.op = NOP; // writes to x0 have no effect
      end
   end

   always_comb
   begin
      a_dst_not_nop: assert final (!(uop.dst_valid && uop.op == NOP))
         else $error("alu_decode: nop with a destination");
   end

endmodule

/* decode/mem_ctrl_decode.sv */
`timescale 1ns/10ps

module mem_ctrl_decode
   import riscv_isa_pkg::*;
   import uop_pkg::*;
#(
   parameter bit CHEAP_TWO_SRC = 1'b0
)
(
   input  insn_t insn,
   input  xlen_t imm_i,
   input  xlen_t imm_s,
   input  xlen_t pc_target,
   output uop_t  uop,
   output logic  match
);

   opcode_t  opcode;
   funct3_t  funct3;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   logic     rs1_is_link;

   assign opcode = insn[6:0];
   assign funct3 = insn[14:12];
   assign rd     = insn[11:7];
   assign rs1    = insn[19:15];
   assign rs2    = insn[24:20];
   assign rs1_is_link = (rs1 == LINK_REG_A) || (rs1 == LINK_REG_B);

   always_comb
   begin
      uop = UOP_NONE;
      match = 1'b1;
      uop.src_a = rs1;
      uop.src_b = rs2;
      case (opcode)
         OPC_LOAD:
         begin
            uop.dst = rd;
            uop.dst_valid = (rd != '0);
            uop.src_a_valid = 1'b1;
            uop.is_mem = 1'b1;
            uop.imm = imm_i;
            case (funct3)
               3'd0: uop.op = LB;
               3'd1: uop.op = LH;
               3'd2: uop.op = LW;
               3'd3: uop.op = LD;
               3'd4: uop.op = LBU;
               3'd5: uop.op = LHU;
               3'd6: uop.op = LWU;
               default: ;
            endcase
         end
         OPC_STORE:
         begin
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1; // store data
            uop.is_mem = 1'b1;
            uop.is_store = 1'b1;
            uop.imm = imm_s;
            case (funct3)
               3'd0: uop.op = SB;
               3'd1: uop.op = SH;
               3'd2: uop.op = SW;
               3'd3: uop.op = SD;
               default: ;
            endcase
         end
         OPC_BRANCH:
         begin
            uop.src_a_valid = 1'b1;
            uop.src_b_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_cheap_int = CHEAP_TWO_SRC;
            uop.is_br = 1'b1;
            uop.imm = pc_target;
            case (funct3)
               3'd0: uop.op = BEQ;
               3'd1: uop.op = BNE;
               3'd4: uop.op = BLT;
               3'd5: uop.op = BGE;
               3'd6: uop.op = BLTU;
               3'd7: uop.op = BGEU;
               default: ;
            endcase
         end
         OPC_JAL:
         begin
            uop.op = (rd == '0) ? J : JAL;
            uop.dst = rd;
            uop.dst_valid = (rd != '0);
            uop.is_int = 1'b1;
            uop.is_cheap_int = (rd != '0); // link write
            uop.is_br = 1'b1;
            uop.imm = pc_target;
         end
         OPC_JALR:
         begin
            if (rd != '0)
               uop.op = JALR;
            else
               uop.op = rs1_is_link ? RET : JR;
            uop.dst = rd;
            uop.dst_valid = (rd != '0);
            uop.src_a_valid = 1'b1;
            uop.is_int = 1'b1;
            uop.is_cheap_int = 1'b1;
            uop.is_br = 1'b1;
            uop.imm = imm_i;
         end
         OPC_FENCE:
            uop.op = NOP; // single issue memory order
         default:
            match = 1'b0;
      endcase

      if (uop.op == ILLEGAL)
         uop = UOP_NONE;
   end

   always_comb
   begin
      a_store_is_mem: assert final (!uop.is_store || uop.is_mem)
         else $error("mem_ctrl_decode: store without is_mem");
   end

endmodule

/* decode/system_decode.sv */
`timescale 1ns/10ps

module system_decode
   import riscv_isa_pkg::*;
   import uop_pkg::*;
(
   input  insn_t insn,
   output uop_t  uop,
   output logic  match
);

   opcode_t  opcode;
   funct3_t  funct3;
   funct12_t funct12;
   reg_idx_t rd;
   reg_idx_t rs1;
   csr_t     csr_id;

   function automatic csr_t decode_csr(input csr_addr_t addr);
      csr_t id;
      case (addr)
         CSR_MSTATUS:  id = MSTATUS;
         CSR_MISA:     id = MISA;
         CSR_MIE:      id = MIE;
         CSR_MTVEC:    id = MTVEC;
         CSR_MSCRATCH: id = MSCRATCH;
         CSR_MEPC:     id = MEPC;
         CSR_MCAUSE:   id = MCAUSE;
         CSR_MTVAL:    id = MTVAL;
         CSR_MIP:      id = MIP;
         CSR_CYCLE:    id = CYCLE_CSR;
         CSR_INSTRET:  id = INSTRET_CSR;
         CSR_MHARTID:  id = MHARTID;
         default:      id = BAD_CSR;
      endcase
      return id;
   endfunction

   assign opcode  = insn[6:0];
   assign funct3  = insn[14:12];
   assign funct12 = insn[31:20];
   assign rd      = insn[11:7];
   assign rs1     = insn[19:15];
   assign csr_id  = decode_csr(funct12);

   always_comb
   begin
      uop = UOP_NONE;
      match = (opcode == OPC_SYSTEM);
      uop.is_int = 1'b1;
      if (match && funct3 == 3'd0 && rd == '0 && rs1 == '0)
      begin
         uop.serializing = 1'b1;
         uop.must_restart = 1'b1;
         case (funct12)
            F12_ECALL:  uop.op = ECALL;
            F12_EBREAK: uop.op = EBREAK;
            F12_MRET:   uop.op = MRET;
            F12_WFI:    uop.op = NOP;
            default: ;
         endcase
      end
      else if (match && funct3 != 3'd0 && funct3 != 3'd4 && csr_id != BAD_CSR)
      begin
         uop.dst = rd;
         uop.dst_valid = (rd != '0);
         uop.src_a = rs1;
         uop.src_a_valid = !funct3[2]; // immediate forms carry uimm in imm
         uop.imm = xlen_t'({rs1, csr_id});
         uop.serializing = 1'b1;
         uop.must_restart = 1'b1;
         case (funct3)
            3'd1: uop.op = CSRRW;
            3'd2: uop.op = CSRRS;
            3'd3: uop.op = CSRRC;
            3'd5: uop.op = CSRRWI;
            3'd6: uop.op = CSRRSI;
            default: uop.op = CSRRCI;
         endcase
         if (funct3 == 3'd2 && rs1 == '0) // plain csr read
         begin
            if (csr_id == MHARTID)
            begin
               uop = UOP_NONE;
               uop.op = (rd == '0) ? NOP : ADD; // single hart, reads as zero
               uop.dst = rd;
               uop.dst_valid = (rd != '0);
               uop.src_a_valid = (rd != '0);
               uop.src_b_valid = (rd != '0);
               uop.is_int = 1'b1;
            end
            else if (csr_id == CYCLE_CSR || csr_id == INSTRET_CSR)
            begin
               uop.op = (csr_id == CYCLE_CSR) ? RDCYCLE : RDINSTRET;
               uop.src_a_valid = 1'b0;
               uop.must_restart = 1'b0;
               uop.imm = '0;
            end
         end
      end

      if (uop.op == ILLEGAL)
         uop = UOP_NONE;
   end

   always_comb
   begin
      a_no_bad_csr: assert final (!(uop.op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI})
                                  || uop.imm[$bits(csr_t)-1:0] != BAD_CSR)
         else $error("system_decode: csr op with unknown csr");
   end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage
   import riscv_isa_pkg::*;
   import uop_pkg::*;
#(
   parameter bit CHEAP_TWO_SRC = 1'b0
)
(
   input  logic  clk,
   input  logic  rst_n,
   input  logic  insn_valid,
   input  insn_t insn,
   input  xlen_t pc,
   input  logic  page_fault,
   input  logic  irq,
   output logic  uop_valid,
   output uop_t  uop
);

   xlen_t imm_i;
   xlen_t imm_s;
   xlen_t imm_u;
   xlen_t pc_target;
   uop_t  alu_uop;
   uop_t  mem_uop;
   uop_t  sys_uop;
   logic  alu_match;
   logic  mem_match;
   logic  sys_match;
   uop_t  next_uop;

   imm_gen i_imm_gen (.insn(insn), .pc(pc), .imm_i(imm_i), .imm_s(imm_s), .imm_u(imm_u),
                      .pc_target(pc_target));

   alu_decode #(.CHEAP_TWO_SRC(CHEAP_TWO_SRC)) i_alu_decode (.insn(insn), .imm_i(imm_i),
      .imm_u(imm_u), .pc_target(pc_target), .uop(alu_uop), .match(alu_match));

   mem_ctrl_decode #(.CHEAP_TWO_SRC(CHEAP_TWO_SRC)) i_mem_ctrl_decode (.insn(insn),
      .imm_i(imm_i), .imm_s(imm_s), .pc_target(pc_target), .uop(mem_uop), .match(mem_match));

   system_decode i_system_decode (.insn(insn), .uop(sys_uop), .match(sys_match));

   always_comb
   begin
      next_uop = UOP_NONE; // no class matched
      if (alu_match)
         next_uop = alu_uop;
      else if (mem_match)
         next_uop = mem_uop;
      else if (sys_match)
         next_uop = sys_uop;

      if (page_fault || irq)
      begin
         next_uop = UOP_NONE;
         next_uop.op = page_fault ? FETCH_PF : IRQ; // fault wins over irq
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         uop_valid <= 1'b0;
         uop <= UOP_NONE;
      end
      else
      begin
         uop_valid <= insn_valid;
         if (insn_valid)
            uop <= next_uop;
      end
   end

   a_one_class: assert property (@(posedge clk) disable iff (!rst_n)
                                 insn_valid |-> $onehot0({alu_match, mem_match, sys_match}));

endmodule

/* test/decode_stage_tb.sv */
`timescale 1ns/10ps

module decode_stage_tb
   import riscv_isa_pkg::*;
   import uop_pkg::*;
;

   logic  clk = 1'b0;
   logic  rst_n;
   logic  insn_valid;
   insn_t insn;
   xlen_t pc;
   logic  page_fault;
   logic  irq;
   logic  uop_valid;
   uop_t  uop;

   insn_t vec_insn[$];
   xlen_t vec_pc[$];
   logic  vec_pf[$];
   logic  vec_irq[$];
   uop_t  vec_exp[$];
   uop_t  pending[$]; // driven but not yet seen at the output

   logic  valid_seen = 1'b0;
   uop_t  exp_uop;
   int    cycle_count = 0;
   int    cycle_limit = 0;

   decode_stage i_decode_stage (.clk(clk), .rst_n(rst_n), .insn_valid(insn_valid), .insn(insn),
      .pc(pc), .page_fault(page_fault), .irq(irq), .uop_valid(uop_valid), .uop(uop));

   initial
   begin
      forever #50 clk = ~clk;
   end

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("Done: errors found");
      $fatal(1, "decode test stopped");
   endtask

   task automatic check_op(input string name, input uop_op_t got, input uop_op_t exp);
      if (got !== exp)
         report_failure($sformatf("FAIL t=%0t %s: got %s expected %s", $time, name,
                                  got.name(), exp.name()));
   endtask

   task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
      if (got !== exp)
         report_failure($sformatf("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
      if (got !== exp)
         report_failure($sformatf("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         report_failure($sformatf("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp));
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic uop_op_t op_from_name(input string name, output bit found);
      uop_op_t op;
      uop_op_t result;
      int      k;
      op = op.first();
      result = op;
      found = 1'b0;
      for (k = 0; k < op.num(); k++)
      begin
         if (op.name() == name)
         begin
            result = op;
            found = 1'b1;
         end
         op = op.next();
      end
      return result;
   endfunction

   task automatic load_vectors();
      int       fd;
      int       code;
      string    line;
      string    op_name;
      bit       found;
      insn_t    f_insn;
      xlen_t    f_pc;
      logic     f_pf;
      logic     f_irq;
      reg_idx_t f_dst;
      reg_idx_t f_src_a;
      reg_idx_t f_src_b;
      logic     f_dv;
      logic     f_av;
      logic     f_bv;
      xlen_t    f_imm;
      logic     f_mem;
      logic     f_store;
      logic     f_br;
      logic     f_ser;
      uop_t     exp;
      fd = $fopen("test/decode_input.txt", "r");
      if (fd == 0)
         report_failure("could not open test/decode_input.txt");
      while (!$feof(fd))
      begin
         line = "";
         code = $fgets(line, fd);
         if (code <= 0 || line.len() < 2 || line[0] == "#")
            continue;
         code = $sscanf(line, "%h %h %d %d %s %d %d %d %d %d %d %h %d %d %d %d",
                        f_insn, f_pc, f_pf, f_irq, op_name, f_dst, f_dv, f_src_a, f_av,
                        f_src_b, f_bv, f_imm, f_mem, f_store, f_br, f_ser);
         if (code != 16)
            report_failure($sformatf("malformed vector line: %s", line));
         exp = '0;
         exp.op = op_from_name(op_name, found);
         if (!found)
            report_failure($sformatf("unknown micro-op name %s in vector file", op_name));
         exp.dst = f_dst;
         exp.dst_valid = f_dv;
         exp.src_a = f_src_a;
         exp.src_a_valid = f_av;
         exp.src_b = f_src_b;
         exp.src_b_valid = f_bv;
         exp.imm = f_imm;
         exp.is_mem = f_mem;
         exp.is_store = f_store;
         exp.is_br = f_br;
         exp.serializing = f_ser;
         vec_insn.push_back(f_insn);
         vec_pc.push_back(f_pc);
         vec_pf.push_back(f_pf);
         vec_irq.push_back(f_irq);
         vec_exp.push_back(exp);
      end
      $fclose(fd);
      if (vec_insn.size() == 0)
         report_failure("the vector file holds no vectors");
   endtask

   // class flags for the default build where two-source ops are not cheap
   task automatic check_class(input uop_op_t op);
      if (op inside {ILLEGAL, FETCH_PF, IRQ})
      begin
         check_flag("uop.is_int", uop.is_int, 1'b0);
         check_flag("uop.is_cheap_int", uop.is_cheap_int, 1'b0);
         check_flag("uop.must_restart", uop.must_restart, 1'b0);
      end
      if (op inside {ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI, LUI, AUIPC})
      begin
         check_flag("uop.is_int", uop.is_int, 1'b1);
         check_flag("uop.is_cheap_int", uop.is_cheap_int, 1'b1);
      end
      if (op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
                     MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
                     BEQ, BNE, BLT, BGE, BLTU, BGEU})
      begin
         check_flag("uop.is_int", uop.is_int, 1'b1);
         check_flag("uop.is_cheap_int", uop.is_cheap_int, 1'b0);
      end
      if (op inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI})
         check_flag("uop.must_restart", uop.must_restart, 1'b1);
   endtask

   // register indices only matter when their valid bit is set
   task automatic compare_uop(input uop_t exp);
      check_op("uop.op", uop.op, exp.op);
      check_flag("uop.dst_valid", uop.dst_valid, exp.dst_valid);
      check_flag("uop.src_a_valid", uop.src_a_valid, exp.src_a_valid);
      check_flag("uop.src_b_valid", uop.src_b_valid, exp.src_b_valid);
      if (exp.dst_valid)
         check_reg("uop.dst", uop.dst, exp.dst);
      if (exp.src_a_valid)
         check_reg("uop.src_a", uop.src_a, exp.src_a);
      if (exp.src_b_valid)
         check_reg("uop.src_b", uop.src_b, exp.src_b);
      check_word("uop.imm", uop.imm, exp.imm);
      check_flag("uop.is_mem", uop.is_mem, exp.is_mem);
      check_flag("uop.is_store", uop.is_store, exp.is_store);
      check_flag("uop.is_br", uop.is_br, exp.is_br);
      check_flag("uop.serializing", uop.serializing, exp.serializing);
      check_class(exp.op);
   endtask

   // outputs are stable at the falling edge
   always @(negedge clk)
   begin
      check_flag("uop_valid", uop_valid, valid_seen); // exactly one cycle behind insn_valid
      if (uop_valid)
      begin
         if (pending.size() == 0)
            report_failure("uop_valid was high with no instruction pending");
         else
         begin
            exp_uop = pending.pop_front();
            compare_uop(exp_uop);
         end
      end
      valid_seen = insn_valid;
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count > cycle_limit)
         report_failure($sformatf("timeout after %0d cycles", cycle_count));
   end

   initial
   begin
      logic [31:0] rng;
      logic [1:0]  idle;
      int          i;
      rst_n = 1'b0;
      insn_valid = 1'b0;
      insn = '0;
      pc = '0;
      page_fault = 1'b0;
      irq = 1'b0;
      rng = 32'd80; // xorshift seed
      load_vectors();
      cycle_limit = vec_insn.size() * 5 + 20;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      for (i = 0; i < vec_insn.size(); i++)
      begin
         rng = xorshift32(rng);
         idle = rng[1:0];
         repeat (idle)
         begin
            @(posedge clk);
            insn_valid <= 1'b0;
         end
         @(posedge clk);
         insn_valid <= 1'b1;
         insn <= vec_insn[i];
         pc <= vec_pc[i];
         page_fault <= vec_pf[i];
         irq <= vec_irq[i];
         pending.push_back(vec_exp[i]);
      end
      @(posedge clk);
      insn_valid <= 1'b0;
      page_fault <= 1'b0;
      irq <= 1'b0;
      while (pending.size() != 0)
         @(negedge clk);
      repeat (2) @(posedge clk); // no stray uop_valid afterwards
      $display("Done: no errors");
      $finish;
   end

endmodule

/* test/decode_input.txt */
# insn pc page_fault irq op dst dst_valid src_a src_a_valid src_b src_b_valid
# imm(hex) is_mem is_store is_br serializing
002081B3 0000000080001000 0 0 ADD 3 1 1 1 2 1 0000000000000000 0 0 0 0
407302B3 0000000080001000 0 0 SUB 5 1 6 1 7 1 0000000000000000 0 0 0 0
02C58533 0000000080001000 0 0 MUL 10 1 11 1 12 1 0000000000000000 0 0 0 0
FFB10093 0000000080001000 0 0 ADDI 1 1 2 1 0 0 FFFFFFFFFFFFFFFB 0 0 0 0
40325213 0000000080001000 0 0 SRAI 4 1 4 1 0 0 0000000000000403 0 0 0 0
00208033 0000000080001000 0 0 NOP 0 0 0 0 0 0 0000000000000000 0 0 0 0
800003B7 0000000080001000 0 0 LUI 7 1 0 0 0 0 FFFFFFFF80000000 0 0 0 0
12345117 0000000080001000 0 0 AUIPC 2 1 0 0 0 0 0000000092346000 0 0 0 0
01053283 0000000080001000 0 0 LD 5 1 10 1 0 0 0000000000000010 1 0 0 0
FFF14303 0000000080001000 0 0 LBU 6 1 2 1 0 0 FFFFFFFFFFFFFFFF 1 0 0 0
00007083 0000000080001000 0 0 ILLEGAL 0 0 0 0 0 0 0000000000000000 0 0 0 0
FE713C23 0000000080001000 0 0 SD 0 0 2 1 7 1 FFFFFFFFFFFFFFF8 1 1 0 0
00208463 0000000080001000 0 0 BEQ 0 0 1 1 2 1 0000000080001008 0 0 1 0
FE4198E3 0000000080001000 0 0 BNE 0 0 3 1 4 1 0000000080000FF0 0 0 1 0
001000EF 0000000080001000 0 0 JAL 1 1 0 0 0 0 0000000080001800 0 0 1 0
00008067 0000000080001000 0 0 RET 0 0 1 1 0 0 0000000000000000 0 0 1 0
00C300E7 0000000080001000 0 0 JALR 1 1 6 1 0 0 000000000000000C 0 0 1 0
00000073 0000000080001000 0 0 ECALL 0 0 0 0 0 0 0000000000000000 0 0 0 1
30200073 0000000080001000 0 0 MRET 0 0 0 0 0 0 0000000000000000 0 0 0 1
340312F3 0000000080001000 0 0 CSRRW 5 1 6 1 0 0 0000000000000064 0 0 0 1
F1402573 0000000080001000 0 0 ADD 10 1 0 1 0 1 0000000000000000 0 0 0 0
C00025F3 0000000080001000 0 0 RDCYCLE 11 1 0 0 0 0 0000000000000000 0 0 0 1
7C0110F3 0000000080001000 0 0 ILLEGAL 0 0 0 0 0 0 0000000000000000 0 0 0 0
0000000B 0000000080001000 0 0 ILLEGAL 0 0 0 0 0 0 0000000000000000 0 0 0 0
002081B3 0000000080001000 1 1 FETCH_PF 0 0 0 0 0 0 0000000000000000 0 0 0 0
01053283 0000000080001000 0 1 IRQ 0 0 0 0 0 0 0000000000000000 0 0 0 0

/* filelist.f */
common/riscv_isa_pkg.sv
common/uop_pkg.sv
source/imm_gen.sv
decode/alu_decode.sv
decode/mem_ctrl_decode.sv
decode/system_decode.sv
source/decode_stage.sv
test/decode_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module decode_stage_tb \
   -o decode_stage_sim

./obj_dir/decode_stage_sim
